// ==== bench/fe_frontend_assertions.sv ====
// concurrent checks on the fetch pipeline, bound into fe_frontend
// covers reset quiet, flush clearing s2, and the two-cycle s2 timing

`timescale 1ns/1ps

module fe_frontend_assertions (
  input logic i_clk,
  input logic i_reset_n,
  input logic i_flush,
  input logic i_accept,
  input logic o_fetch_valid,
  input logic o_s2_valid
);

  // no requests while in reset
  a_quiet_in_reset : assert property (@(posedge i_clk) !i_reset_n |-> !o_fetch_valid)
    else $error("fetch valid during reset");

  a_flush_clears_s2 : assert property (@(posedge i_clk) disable iff (!i_reset_n)
                                       i_flush |=> !o_s2_valid)
    else $error("s2 valid one cycle after a flush");

  a_s2_from_request : assert property (@(posedge i_clk) disable iff (!i_reset_n)
                                       o_s2_valid |-> $past(i_accept, 2))
    else $error("s2 valid without a request two cycles earlier");

endmodule

bind fe_frontend fe_frontend_assertions u_assert (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_flush       (w_flush),
  .i_accept      (w_accept),
  .o_fetch_valid (o_fetch_valid),
  .o_s2_valid    (o_s2_valid)
);

// ==== bench/tb_frontend.sv ====
// table-driven testbench for the fetch address sequencer
// a small model tracks the next fetch address, and each table row runs one scenario

`timescale 1ns/1ps

module tb_frontend;
  import fe_pkg::*;

  localparam logic [VADDR_W-1:0] PC_INIT = 32'h8000_0100;
  localparam int K_SEQ = 0, K_TRAP = 1, K_MISP = 2, K_BTB = 3;
  localparam int K_MISS = 4, K_STALL = 5, K_AGE = 6;

  typedef struct {
    int                   kind;
    except_t              cause;
    logic [MEDELEG_W-1:0] medeleg;
    logic [VADDR_W-1:0]   a;
    logic [VADDR_W-1:0]   b;
    logic [CMT_ID_W-1:0]  cmt1;
    logic [DISP_W-1:0]    grp1;
    logic [CMT_ID_W-1:0]  cmt2;
    logic [DISP_W-1:0]    grp2;
    logic [VADDR_W-1:0]   expv;
  } row_t;

  logic i_clk, i_reset_n, i_ic_ready, i_s2_miss, i_ibuf_ready;
  logic i_commit_valid;
  except_t i_commit_cause;
  logic [VADDR_W-1:0] i_commit_epc, i_mepc, i_sepc, i_mtvec, i_stvec;
  logic [CMT_ID_W-1:0] i_commit_cmt_id, i_br_cmt_id;
  logic [DISP_W-1:0] i_commit_grp_id, i_br_grp_id;
  logic [MEDELEG_W-1:0] i_medeleg;
  logic i_br_update, i_br_taken, i_br_mispredict;
  logic [VADDR_W-1:0] i_br_pc, i_br_target;
  logic o_fetch_valid, o_s2_valid, o_s2_predicted;
  fetch_addr_u o_fetch_vaddr;
  logic [VADDR_W-1:0] o_s2_vaddr;

  row_t               rows[$];
  logic [VADDR_W-1:0] exp_pc;
  logic               hist_v[2];
  logic [VADDR_W-1:0] hist_a[2];
  logic [31:0]        lfsr;

  fe_frontend #(.PC_INIT(PC_INIT)) dut0 (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // ====================================================================
  // checks and helpers
  // ====================================================================
  task automatic check_addr(input fetch_addr_u got, input fetch_addr_u exp, input string what);
    if (got.raw !== exp.raw) begin
      $display("error at %0t: %s got %h expected %h", $time, what, got.raw, exp.raw);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] x);
    return x[0] ? ((x >> 1) ^ 32'h8020_0003) : (x >> 1);
  endfunction

  function automatic logic [VADDR_W-1:0] next_block(input logic [VADDR_W-1:0] a);
    return (a & ~VADDR_W'(FETCH_BYTES - 1)) + VADDR_W'(FETCH_BYTES);
  endfunction

  task automatic add_row(input int kind, input except_t cause, input logic [15:0] deleg,
                         input logic [31:0] a, input logic [31:0] b,
                         input logic [4:0] c1, input logic [1:0] g1,
                         input logic [4:0] c2, input logic [1:0] g2,
                         input logic [31:0] expv);
    row_t r;
    r = '{kind, cause, deleg, a, b, c1, g1, c2, g2, expv};
    rows.push_back(r);
  endtask

  // called after the falling edge drive to update the next address model
  task automatic sample_cycle();
    logic               acc;
    logic               flush;
    logic [VADDR_W-1:0] s2_exp;
    #1;
    acc    = o_fetch_valid & i_ic_ready;
    flush  = i_commit_valid | (i_br_update & i_br_mispredict);
    s2_exp = hist_a[1];
    if (o_fetch_valid) check_addr(o_fetch_vaddr, exp_pc, "fetch address");
    if (o_s2_valid) begin
      check_bit(hist_v[1], 1'b1, "s2 request accepted");
      check_addr(o_s2_vaddr, s2_exp, "s2 address");
    end
    hist_v[1] = hist_v[0];
    hist_a[1] = hist_a[0];
    hist_v[0] = acc;
    hist_a[0] = exp_pc;
    if (o_s2_valid && (i_s2_miss || !i_ibuf_ready) && !flush) begin
      exp_pc = s2_exp;   // retry restarts at the s2 block
    end else if (acc) begin
      exp_pc = next_block(exp_pc);
    end
  endtask

  // ====================================================================
  // scenarios
  // ====================================================================
  task automatic seq_fetch(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge i_clk);
      lfsr = lfsr_step(lfsr);
      i_ic_ready = lfsr[0];
      sample_cycle();
      check_bit(o_fetch_valid, 1'b1, "fetch valid");
    end
    @(negedge i_clk);
    i_ic_ready = 1'b1;
    sample_cycle();
  endtask

  task automatic trap_flush(input row_t r);
    @(negedge i_clk);
    i_commit_valid  = 1'b1;
    i_commit_cause  = r.cause;
    i_commit_epc    = r.a;
    i_medeleg       = r.medeleg;
    i_commit_cmt_id = r.cmt1;
    i_commit_grp_id = r.grp1;
    exp_pc = r.expv;
    sample_cycle();
    @(negedge i_clk);
    i_commit_valid = 1'b0;
    sample_cycle();   // aligned target plus one block
  endtask

  task automatic mispredict_flush(input logic [31:0] target);
    @(negedge i_clk);
    i_br_update     = 1'b1;
    i_br_mispredict = 1'b1;
    i_br_taken      = 1'b0;
    i_br_pc         = 32'h0000_0f00;   // untrained btb slot
    i_br_target     = target;
    exp_pc = target;
    sample_cycle();
    @(negedge i_clk);
    i_br_update     = 1'b0;
    i_br_mispredict = 1'b0;
    sample_cycle();
  endtask

  task automatic btb_predict(input row_t r);
    @(negedge i_clk);
    i_br_update = 1'b1;   // train or untrain, no flush
    i_br_taken  = r.expv[0];
    i_br_pc     = r.a;
    i_br_target = r.b;
    sample_cycle();
    mispredict_flush(r.a - 32'd8);   // fetch the block before the branch
    @(negedge i_clk);
    exp_pc = r.expv[0] ? r.b : next_block(r.a);
    sample_cycle();
    @(negedge i_clk);
    sample_cycle();
    check_bit(o_s2_valid, 1'b1, "branch block in s2");
    check_addr(o_s2_vaddr, r.a, "branch block address");
    check_bit(o_s2_predicted, r.expv[0], "s2 predicted");
  endtask

  task automatic retry_block(input logic ibuf_stall);
    logic [VADDR_W-1:0] x;
    int                 n;
    n = 0;
    @(negedge i_clk);
    while (!o_s2_valid && n < 8) begin
      sample_cycle();
      @(negedge i_clk);
      n++;
    end
    x = o_s2_vaddr;
    if (ibuf_stall) i_ibuf_ready = 1'b0;
    else i_s2_miss = 1'b1;
    sample_cycle();
    for (int i = 0; i < 3; i++) begin
      @(negedge i_clk);
      i_s2_miss  = 1'b0;
      i_ic_ready = ibuf_stall;   // ibuf stall waits on the buffer alone
      sample_cycle();
      if (ibuf_stall) check_bit(o_fetch_valid & i_ic_ready, 1'b0, "request while waiting");
    end
    n = 0;
    @(negedge i_clk);
    i_ic_ready   = 1'b1;
    i_ibuf_ready = 1'b1;
    sample_cycle();
    while (!o_s2_valid) begin
      n++;
      if (n > 8) begin
        $display("TESTBENCH FAILED");
        $fatal(1, "retried block never reached s2");
      end
      @(negedge i_clk);
      sample_cycle();
    end
    check_addr(o_s2_vaddr, x, "retried s2 address");
  endtask

  task automatic flush_age(input row_t r);
    @(negedge i_clk);
    i_ic_ready      = 1'b0;
    i_commit_valid  = 1'b1;
    i_commit_cause  = ANOTHER_FLUSH;
    i_commit_epc    = r.a;
    i_commit_cmt_id = r.cmt1;
    i_commit_grp_id = r.grp1;
    exp_pc = r.a;
    sample_cycle();
    @(negedge i_clk);
    i_commit_epc    = r.b;
    i_commit_cmt_id = r.cmt2;
    i_commit_grp_id = r.grp2;
    exp_pc = r.expv;
    sample_cycle();
    @(negedge i_clk);
    i_commit_valid = 1'b0;
    sample_cycle();
    repeat (2) begin
      @(negedge i_clk);
      i_ic_ready = 1'b1;
      sample_cycle();
    end
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial begin
    i_reset_n = 1'b0;
    i_ic_ready = 1'b0;
    i_s2_miss = 1'b0;
    i_ibuf_ready = 1'b1;
    i_commit_valid = 1'b0;
    i_commit_cause = ANOTHER_FLUSH;
    i_commit_epc = '0;
    i_commit_cmt_id = '0;
    i_commit_grp_id = '0;
    i_mepc = 32'h0000_3104;
    i_sepc = 32'h0000_4208;
    i_mtvec = 32'h0000_5000;
    i_stvec = 32'h0000_6000;
    i_medeleg = '0;
    i_br_update = 1'b0;
    i_br_pc = '0;
    i_br_target = '0;
    i_br_taken = 1'b0;
    i_br_mispredict = 1'b0;
    i_br_cmt_id = '0;
    i_br_grp_id = '0;
    exp_pc = PC_INIT;
    hist_v = '{1'b0, 1'b0};
    hist_a = '{32'h0, 32'h0};
    lfsr = 32'hafd9_a7ce;

    add_row(K_SEQ, ANOTHER_FLUSH, 16'h0, 32'd24, 32'h0, 5'd0, 2'd1, 5'd0, 2'd1, 32'h0);
    add_row(K_TRAP, SILENT_FLUSH, 16'h0, 32'h7010, 0, 5'd1, 2'd1, 0, 0, 32'h7014);
    add_row(K_TRAP, ANOTHER_FLUSH, 16'h0, 32'h7010, 0, 5'd2, 2'd1, 0, 0, 32'h7010);
    add_row(K_TRAP, MRET, 16'h0, 32'h7010, 0, 5'd3, 2'd1, 0, 0, 32'h3104);
    add_row(K_TRAP, SRET, 16'h0, 32'h7010, 0, 5'd4, 2'd1, 0, 0, 32'h4208);
    add_row(K_TRAP, ECALL_U, 16'h0100, 32'h7010, 0, 5'd5, 2'd1, 0, 0, 32'h6000);
    add_row(K_TRAP, ECALL_U, 16'h0000, 32'h7010, 0, 5'd6, 2'd1, 0, 0, 32'h5000);
    add_row(K_TRAP, ECALL_S, 16'h0200, 32'h7010, 0, 5'd7, 2'd1, 0, 0, 32'h6000);
    add_row(K_TRAP, ECALL_M, 16'h0800, 32'h7010, 0, 5'd8, 2'd1, 0, 0, 32'h6000);
    add_row(K_TRAP, ECALL_M, 16'h0000, 32'h7010, 0, 5'd9, 2'd1, 0, 0, 32'h5000);
    add_row(K_TRAP, INST_ACC_FAULT, 16'h0002, 32'h7010, 0, 5'd10, 2'd1, 0, 0, 32'h6000);
    add_row(K_TRAP, INST_PAGE_FAULT, 16'h1000, 32'h7010, 0, 5'd11, 2'd1, 0, 0, 32'h6000);
    add_row(K_TRAP, INST_PAGE_FAULT, 16'h0002, 32'h7010, 0, 5'd12, 2'd1, 0, 0, 32'h5000);
    add_row(K_TRAP, ILLEGAL_INST, 16'h0800, 32'h7010, 0, 5'd13, 2'd1, 0, 0, 32'h6000);
    add_row(K_TRAP, ILLEGAL_INST, 16'h0004, 32'h7010, 0, 5'd14, 2'd1, 0, 0, 32'h5000);
    add_row(K_MISP, ANOTHER_FLUSH, 16'h0, 32'h9044, 0, 0, 0, 0, 0, 32'h0);
    add_row(K_BTB, ANOTHER_FLUSH, 16'h0, 32'ha008, 32'hb020, 0, 0, 0, 0, 32'h1);
    add_row(K_BTB, ANOTHER_FLUSH, 16'h0, 32'ha008, 32'hb020, 0, 0, 0, 0, 32'h0);
    add_row(K_MISS, ANOTHER_FLUSH, 16'h0, 0, 0, 0, 0, 0, 0, 32'h0);
    add_row(K_STALL, ANOTHER_FLUSH, 16'h0, 0, 0, 0, 0, 0, 0, 32'h0);
    // older then younger, younger then older, across a wrap, same id
    add_row(K_AGE, ANOTHER_FLUSH, 16'h0, 32'hc000, 32'hd000, 5'd3, 2'd1, 5'd5, 2'd1, 32'hc000);
    add_row(K_AGE, ANOTHER_FLUSH, 16'h0, 32'he000, 32'hf000, 5'd9, 2'd1, 5'd4, 2'd1, 32'hf000);
    add_row(K_AGE, ANOTHER_FLUSH, 16'h0, 32'hc100, 32'hd100, 5'd14, 2'd1, 5'd18, 2'd1, 32'hc100);
    add_row(K_AGE, ANOTHER_FLUSH, 16'h0, 32'hc200, 32'hd200, 5'd7, 2'd2, 5'd7, 2'd1, 32'hd200);

    repeat (4) @(negedge i_clk);
    i_reset_n = 1'b1;
    sample_cycle();
    check_bit(o_fetch_valid, 1'b0, "fetch valid in init");

    foreach (rows[i]) begin
      case (rows[i].kind)
        K_SEQ   : seq_fetch(int'(rows[i].a));
        K_TRAP  : trap_flush(rows[i]);
        K_MISP  : mispredict_flush(rows[i].a);
        K_BTB   : btb_predict(rows[i]);
        K_MISS  : retry_block(1'b0);
        K_STALL : retry_block(1'b1);
        default : flush_age(rows[i]);
      endcase
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

  // watchdog allows 40 cycles per table row
  initial begin
    #1;
    repeat (rows.size() * 40 + 20) @(posedge i_clk);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog timeout, the run did not finish");
  end

endmodule

// ==== files.f ====
rtl/fe_pkg.sv
rtl/fe_redirect_target.sv
rtl/fe_flush_tracker.sv
rtl/fe_btb.sv
rtl/fe_fetch_fsm.sv
rtl/fe_fetch_stages.sv
rtl/fe_frontend.sv
bench/fe_frontend_assertions.sv
bench/tb_frontend.sv

// ==== rtl/fe_btb.sv ====
// direct-mapped branch target buffer, one entry per fetch block index
// searched with the accepted s0 address and answering with hit and target at s1

`timescale 1ns/1ps

module fe_btb (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_s0_valid,
  input  fe_pkg::fetch_addr_u        i_s0_vaddr,
  input  logic                       i_br_update,
  input  logic [fe_pkg::VADDR_W-1:0] i_br_pc,
  input  logic [fe_pkg::VADDR_W-1:0] i_br_target,
  input  logic                       i_br_taken,
  output logic                       o_s1_hit,
  output logic [fe_pkg::VADDR_W-1:0] o_s1_target
);
  import fe_pkg::*;

  localparam int ENTRIES = 1 << BTB_IDX_W;

  logic [ENTRIES-1:0]   r_valid;
  logic [BTB_TAG_W-1:0] r_tag    [ENTRIES];
  logic [VADDR_W-1:0]   r_target [ENTRIES];
  fetch_addr_u          w_upd;
  logic                 w_upd_match;
  logic                 w_s0_match;

  assign w_upd.raw   = i_br_pc;
  assign w_upd_match = r_valid[w_upd.f.idx] & (r_tag[w_upd.f.idx] == w_upd.f.tag);
  assign w_s0_match  = r_valid[i_s0_vaddr.f.idx] &
                       (r_tag[i_s0_vaddr.f.idx] == i_s0_vaddr.f.tag);

  // ====================================================================
  // update from resolved branches
  // ====================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_br_update) begin
      if (i_br_taken) begin
        r_valid[w_upd.f.idx] <= 1'b1;
      end else if (w_upd_match) begin
        r_valid[w_upd.f.idx] <= 1'b0;   // drop a stale prediction
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_br_update & i_br_taken) begin
      r_tag[w_upd.f.idx]    <= w_upd.f.tag;
      r_target[w_upd.f.idx] <= i_br_target;
    end
  end

  // ====================================================================
  // s1 response
  // ====================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_s1_hit <= 1'b0;
    end else begin
      o_s1_hit <= i_s0_valid & w_s0_match;   // old contents on a same-cycle update
    end
  end

  always_ff @(posedge i_clk) begin
    o_s1_target <= r_target[i_s0_vaddr.f.idx];
  end

endmodule

// ==== rtl/fe_fetch_fsm.sv ====
// fetch state machine and s0 address register
// picks the address presented to the cache each cycle: flush target,
// btb target from s1, or the held sequential address

`timescale 1ns/1ps

module fe_fetch_fsm #(
  parameter logic [fe_pkg::VADDR_W-1:0] PC_INIT = 32'h8000_0000
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_ic_ready,
  input  logic                       i_ibuf_ready,
  input  logic                       i_flush,
  input  logic                       i_pending_older,
  input  logic [fe_pkg::VADDR_W-1:0] i_flush_target,
  input  logic                       i_s1_redirect,
  input  logic [fe_pkg::VADDR_W-1:0] i_s1_target,
  input  logic                       i_s2_ic_miss,
  input  logic                       i_s2_ibuf_stall,
  input  logic [fe_pkg::VADDR_W-1:0] i_s2_vaddr,
  output logic                       o_fetch_valid,
  output fe_pkg::fetch_addr_u        o_fetch_vaddr
);
  import fe_pkg::*;

  localparam logic [2:0] INIT            = 3'd0;
  localparam logic [2:0] FETCH_REQ       = 3'd1;
  localparam logic [2:0] WAIT_IC_FILL    = 3'd2;
  localparam logic [2:0] WAIT_IBUF_FREE  = 3'd3;
  localparam logic [2:0] WAIT_FLUSH_FREE = 3'd4;

  logic [2:0]         r_state;
  logic [2:0]         w_state_next;
  logic [VADDR_W-1:0] r_s0_vaddr;
  logic [VADDR_W-1:0] w_s0_next;
  logic               w_take_flush;
  logic               w_accept;
  fetch_addr_u        w_aligned;
  logic [VADDR_W-1:0] w_seq_next;

  // a held older flush keeps its target against a younger one
  assign w_take_flush = i_flush & ~((r_state == WAIT_FLUSH_FREE) & i_pending_older);
  assign w_accept     = o_fetch_valid & i_ic_ready;

  always_comb begin
    case (r_state)
      INIT           : o_fetch_valid = 1'b0;
      WAIT_IBUF_FREE : o_fetch_valid = i_ibuf_ready;
      default        : o_fetch_valid = 1'b1;
    endcase
  end

  // ====================================================================
  // s0 address select
  // ====================================================================
  always_comb begin
    if (w_take_flush) begin
      o_fetch_vaddr.raw = i_flush_target;
    end else if (i_s1_redirect) begin
      o_fetch_vaddr.raw = i_s1_target;
    end else begin
      o_fetch_vaddr.raw = r_s0_vaddr;
    end
  end

  always_comb begin
    w_aligned       = o_fetch_vaddr;
    w_aligned.f.off = '0;   // block start
  end
  assign w_seq_next = w_aligned.raw + VADDR_W'(FETCH_BYTES);

  // ====================================================================
  // next state
  // ====================================================================
  always_comb begin
    w_state_next = r_state;
    w_s0_next    = o_fetch_vaddr.raw;   // hold what was presented
    case (r_state)
      INIT: begin
        w_state_next = i_flush ? WAIT_FLUSH_FREE : FETCH_REQ;
      end
      FETCH_REQ: begin
        if (i_flush) begin
          if (w_accept) begin
            w_s0_next = w_seq_next;
          end else begin
            w_state_next = WAIT_FLUSH_FREE;
          end
        end else if (i_s2_ic_miss) begin
          w_state_next = WAIT_IC_FILL;
          w_s0_next    = i_s2_vaddr;   // refetch the missed block
        end else if (i_s2_ibuf_stall) begin
          w_state_next = WAIT_IBUF_FREE;
          w_s0_next    = i_s2_vaddr;
        end else if (w_accept) begin
          w_s0_next = w_seq_next;
        end
      end
      default: begin   // wait states end on the first accepted request
        if (w_accept) begin
          w_state_next = FETCH_REQ;
          w_s0_next    = w_seq_next;
        end else if (w_take_flush) begin
          w_state_next = WAIT_FLUSH_FREE;
        end
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= INIT;
      r_s0_vaddr <= PC_INIT;
    end else begin
      r_state    <= w_state_next;
      r_s0_vaddr <= w_s0_next;
    end
  end

endmodule

// ==== rtl/fe_fetch_stages.sv ====
// s1 and s2 request pipeline with clear tracking
// raises the s2 retry events and hides cleared blocks from o_s2_valid

`timescale 1ns/1ps

module fe_fetch_stages (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_accept,
  input  logic [fe_pkg::VADDR_W-1:0] i_s0_vaddr,
  input  logic                       i_flush,
  input  logic                       i_btb_hit,
  input  logic                       i_s2_miss,
  input  logic                       i_ibuf_ready,
  output logic                       o_s1_redirect,
  output logic                       o_s2_ic_miss,
  output logic                       o_s2_ibuf_stall,
  output logic                       o_s2_valid,
  output logic [fe_pkg::VADDR_W-1:0] o_s2_vaddr,
  output logic                       o_s2_predicted
);
  import fe_pkg::*;

  logic               r_s1_valid;
  logic               r_s1_clear;
  logic [VADDR_W-1:0] r_s1_vaddr;
  logic               r_s2_valid;
  logic               r_s2_clear;
  logic               w_s2_stall;

  assign o_s1_redirect   = r_s1_valid & ~r_s1_clear & i_btb_hit;
  assign o_s2_valid      = r_s2_valid & ~r_s2_clear;
  assign o_s2_ic_miss    = o_s2_valid & i_s2_miss;
  assign o_s2_ibuf_stall = o_s2_valid & ~i_s2_miss & ~i_ibuf_ready;   // miss wins
  assign w_s2_stall      = o_s2_ic_miss | o_s2_ibuf_stall;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s1_clear <= 1'b0;
      r_s2_valid <= 1'b0;
      r_s2_clear <= 1'b0;
    end else begin
      r_s1_valid <= i_accept;
      // request issued during a retry is refetched later
      r_s1_clear <= w_s2_stall & ~i_flush;
      r_s2_valid <= r_s1_valid;
      r_s2_clear <= r_s1_clear | i_flush | w_s2_stall;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_vaddr     <= i_s0_vaddr;
    o_s2_vaddr     <= r_s1_vaddr;
    o_s2_predicted <= o_s1_redirect;   // block that redirected fetch
  end

endmodule

// ==== rtl/fe_flush_tracker.sv ====
// forms the flush strobe from commit and branch, and keeps the age
// tag of the latest flush so a younger one cannot override an older one

`timescale 1ns/1ps

module fe_flush_tracker (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_commit_valid,
  input  logic [fe_pkg::CMT_ID_W-1:0] i_commit_cmt_id,
  input  logic [fe_pkg::DISP_W-1:0]   i_commit_grp_id,
  input  logic                        i_br_update,
  input  logic                        i_br_mispredict,
  input  logic [fe_pkg::CMT_ID_W-1:0] i_br_cmt_id,
  input  logic [fe_pkg::DISP_W-1:0]   i_br_grp_id,
  output logic                        o_flush,
  output logic                        o_pending_older
);
  import fe_pkg::*;

  logic                r_flush_valid;
  logic [CMT_ID_W-1:0] r_flush_cmt_id;
  logic [DISP_W-1:0]   r_flush_grp_id;
  logic [CMT_ID_W-1:0] w_cmt_id;
  logic [DISP_W-1:0]   w_grp_id;

  // true when a is older than b
  function automatic logic is_older(input logic [CMT_ID_W-1:0] a_cmt,
                                    input logic [DISP_W-1:0]   a_grp,
                                    input logic [CMT_ID_W-1:0] b_cmt,
                                    input logic [DISP_W-1:0]   b_grp);
    logic [CMT_IDX_W-1:0] a_idx;
    logic [CMT_IDX_W-1:0] b_idx;
    a_idx = a_cmt[CMT_IDX_W-1:0];
    b_idx = b_cmt[CMT_IDX_W-1:0];
    if (a_cmt == b_cmt) begin
      return a_grp < b_grp;
    end else if (a_cmt[CMT_WRAP_BIT] == b_cmt[CMT_WRAP_BIT]) begin
      return a_idx < b_idx;
    end
    return a_idx > b_idx;   // b has wrapped past a
  endfunction

  assign o_flush  = i_commit_valid | (i_br_update & i_br_mispredict);
  assign w_cmt_id = i_commit_valid ? i_commit_cmt_id : i_br_cmt_id;
  assign w_grp_id = i_commit_valid ? i_commit_grp_id : i_br_grp_id;

  assign o_pending_older = r_flush_valid &
                           is_older(r_flush_cmt_id, r_flush_grp_id, w_cmt_id, w_grp_id);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_flush_valid <= 1'b0;
    end else if (o_flush) begin
      r_flush_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_flush) begin
      r_flush_cmt_id <= w_cmt_id;
      r_flush_grp_id <= w_grp_id;
    end
  end

endmodule

// ==== rtl/fe_frontend.sv ====
// top of the fetch address sequencer
// cache and instruction buffer appear only as ready levels and miss pulses

`timescale 1ns/1ps

module fe_frontend #(
  parameter logic [fe_pkg::VADDR_W-1:0] PC_INIT = 32'h8000_0000
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_ic_ready,
  input  logic                         i_s2_miss,
  input  logic                         i_ibuf_ready,
  input  logic                         i_commit_valid,
  input  fe_pkg::except_t              i_commit_cause,
  input  logic [fe_pkg::VADDR_W-1:0]   i_commit_epc,
  input  logic [fe_pkg::CMT_ID_W-1:0]  i_commit_cmt_id,
  input  logic [fe_pkg::DISP_W-1:0]    i_commit_grp_id,
  input  logic [fe_pkg::VADDR_W-1:0]   i_mepc,
  input  logic [fe_pkg::VADDR_W-1:0]   i_sepc,
  input  logic [fe_pkg::VADDR_W-1:0]   i_mtvec,
  input  logic [fe_pkg::VADDR_W-1:0]   i_stvec,
  input  logic [fe_pkg::MEDELEG_W-1:0] i_medeleg,
  input  logic                         i_br_update,
  input  logic [fe_pkg::VADDR_W-1:0]   i_br_pc,
  input  logic [fe_pkg::VADDR_W-1:0]   i_br_target,
  input  logic                         i_br_taken,
  input  logic                         i_br_mispredict,
  input  logic [fe_pkg::CMT_ID_W-1:0]  i_br_cmt_id,
  input  logic [fe_pkg::DISP_W-1:0]    i_br_grp_id,
  output logic                         o_fetch_valid,
  output fe_pkg::fetch_addr_u          o_fetch_vaddr,
  output logic                         o_s2_valid,
  output logic [fe_pkg::VADDR_W-1:0]   o_s2_vaddr,
  output logic                         o_s2_predicted
);
  import fe_pkg::*;

  logic [VADDR_W-1:0] w_flush_target;
  logic               w_flush;
  logic               w_pending_older;
  logic               w_accept;
  logic               w_btb_hit;
  logic [VADDR_W-1:0] w_btb_target;
  logic               w_s1_redirect;
  logic               w_s2_ic_miss;
  logic               w_s2_ibuf_stall;

  assign w_accept = o_fetch_valid & i_ic_ready;

  fe_redirect_target u_target (
    .i_commit_valid (i_commit_valid),
    .i_commit_cause (i_commit_cause),
    .i_commit_epc   (i_commit_epc),
    .i_mepc         (i_mepc),
    .i_sepc         (i_sepc),
    .i_mtvec        (i_mtvec),
    .i_stvec        (i_stvec),
    .i_medeleg      (i_medeleg),
    .i_br_target    (i_br_target),
    .o_target       (w_flush_target)
  );

  fe_flush_tracker u_flush (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_commit_valid  (i_commit_valid),
    .i_commit_cmt_id (i_commit_cmt_id),
    .i_commit_grp_id (i_commit_grp_id),
    .i_br_update     (i_br_update),
    .i_br_mispredict (i_br_mispredict),
    .i_br_cmt_id     (i_br_cmt_id),
    .i_br_grp_id     (i_br_grp_id),
    .o_flush         (w_flush),
    .o_pending_older (w_pending_older)
  );

  fe_btb u_btb (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_s0_valid  (w_accept),
    .i_s0_vaddr  (o_fetch_vaddr),
    .i_br_update (i_br_update),
    .i_br_pc     (i_br_pc),
    .i_br_target (i_br_target),
    .i_br_taken  (i_br_taken),
    .o_s1_hit    (w_btb_hit),
    .o_s1_target (w_btb_target)
  );

  fe_fetch_fsm #(
    .PC_INIT (PC_INIT)
  ) u_fsm (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_ic_ready      (i_ic_ready),
    .i_ibuf_ready    (i_ibuf_ready),
    .i_flush         (w_flush),
    .i_pending_older (w_pending_older),
    .i_flush_target  (w_flush_target),
    .i_s1_redirect   (w_s1_redirect),
    .i_s1_target     (w_btb_target),
    .i_s2_ic_miss    (w_s2_ic_miss),
    .i_s2_ibuf_stall (w_s2_ibuf_stall),
    .i_s2_vaddr      (o_s2_vaddr),
    .o_fetch_valid   (o_fetch_valid),
    .o_fetch_vaddr   (o_fetch_vaddr)
  );

  fe_fetch_stages u_stages (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_accept        (w_accept),
    .i_s0_vaddr      (o_fetch_vaddr.raw),
    .i_flush         (w_flush),
    .i_btb_hit       (w_btb_hit),
    .i_s2_miss       (i_s2_miss),
    .i_ibuf_ready    (i_ibuf_ready),
    .o_s1_redirect   (w_s1_redirect),
    .o_s2_ic_miss    (w_s2_ic_miss),
    .o_s2_ibuf_stall (w_s2_ibuf_stall),
    .o_s2_valid      (o_s2_valid),
    .o_s2_vaddr      (o_s2_vaddr),
    .o_s2_predicted  (o_s2_predicted)
  );

endmodule

// ==== rtl/fe_pkg.sv ====
// shared widths, flush causes and the fetch address view for the
// fetch address sequencer; compile ahead of every rtl module

package fe_pkg;

  // ====================================================================
  // address and block geometry
  // ====================================================================
  localparam int VADDR_W     = 32;
  localparam int FETCH_BYTES = 8;
  localparam int FETCH_OFF_W = $clog2(FETCH_BYTES);
  localparam int BTB_IDX_W   = 4;   // 16 entries
  localparam int BTB_TAG_W   = VADDR_W - BTB_IDX_W - FETCH_OFF_W;

  // ====================================================================
  // commit age
  // ====================================================================
  localparam int CMT_ID_W     = 5;
  localparam int CMT_IDX_W    = CMT_ID_W - 1;
  localparam int CMT_WRAP_BIT = CMT_ID_W - 1;   // flips on every rob wrap
  localparam int DISP_W       = 2;              // one-hot group id

  localparam int CAUSE_W   = 4;
  localparam int MEDELEG_W = 1 << CAUSE_W;

  // trap causes use the riscv codes so they index medeleg directly;
  // non-trap flushes sit on codes the frontend never traps on
  typedef enum logic [CAUSE_W-1:0] {
    INST_ACC_FAULT  = 4'd1,
    ILLEGAL_INST    = 4'd2,
    MRET            = 4'd6,
    SRET            = 4'd7,
    ECALL_U         = 4'd8,
    ECALL_S         = 4'd9,
    SILENT_FLUSH    = 4'd10,
    ECALL_M         = 4'd11,
    INST_PAGE_FAULT = 4'd12,
    ANOTHER_FLUSH   = 4'd14
  } except_t;

  // raw for the sequencer, tag/idx/off for btb and block alignment
  typedef union packed {
    logic [VADDR_W-1:0] raw;
    struct packed {
      logic [BTB_TAG_W-1:0]   tag;
      logic [BTB_IDX_W-1:0]   idx;
      logic [FETCH_OFF_W-1:0] off;
    } f;
  } fetch_addr_u;

endpackage

// ==== rtl/fe_redirect_target.sv ====
// restart address for a flushing commit or a branch mispredict
// purely combinational and a commit always wins over the branch target

`timescale 1ns/1ps

module fe_redirect_target (
  input  logic                         i_commit_valid,
  input  fe_pkg::except_t              i_commit_cause,
  input  logic [fe_pkg::VADDR_W-1:0]   i_commit_epc,
  input  logic [fe_pkg::VADDR_W-1:0]   i_mepc,
  input  logic [fe_pkg::VADDR_W-1:0]   i_sepc,
  input  logic [fe_pkg::VADDR_W-1:0]   i_mtvec,
  input  logic [fe_pkg::VADDR_W-1:0]   i_stvec,
  input  logic [fe_pkg::MEDELEG_W-1:0] i_medeleg,
  input  logic [fe_pkg::VADDR_W-1:0]   i_br_target,
  output logic [fe_pkg::VADDR_W-1:0]   o_target
);
  import fe_pkg::*;

  logic               w_deleg;
  logic [VADDR_W-1:0] w_trap_vec;

  // illegal inst follows the ecall_m delegation bit
  assign w_deleg = (i_commit_cause == ILLEGAL_INST) ? i_medeleg[ECALL_M] :
                                                      i_medeleg[i_commit_cause];
  assign w_trap_vec = w_deleg ? i_stvec : i_mtvec;

  always_comb begin
    if (!i_commit_valid) begin
      o_target = i_br_target;   // mispredict restart
    end else begin
      case (i_commit_cause)
        SILENT_FLUSH  : o_target = i_commit_epc + VADDR_W'(4);
        ANOTHER_FLUSH : o_target = i_commit_epc;
        MRET          : o_target = i_mepc;
        SRET          : o_target = i_sepc;
        default       : o_target = w_trap_vec;
      endcase
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the frontend testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_frontend \
  -f files.f \
  -o tb_frontend

./obj_dir/tb_frontend
